// ==== src/agu_pkg.sv ====
`default_nettype none

package agu_pkg;

   // address, iteration count, start, shift and increment
   localparam int MEM_ADDR_W = 10;

   // period, duty and delay counters
   localparam int PERIOD_W = 10;

   localparam int MEM_DATA_W = 32;
   localparam int MEM_DEPTH  = 1024;  // one word per address

endpackage

`default_nettype wire

// ==== src/agu_wb_pkg.sv ====
`default_nettype none

package agu_wb_pkg;

   localparam int WB_ADDR_W = 13;  // byte address
   localparam int WB_DATA_W = 32;
   localparam int WB_SEL_W  = WB_DATA_W / 8;

   localparam int MEM_WIN_BIT = 12;               // 1 = memory window, 0 = registers
   localparam int REG_OFF_W   = MEM_WIN_BIT - 2;  // word offset below the window bit

   // word offsets in register space
   localparam logic [REG_OFF_W-1:0] REG_START  = 'd0;
   localparam logic [REG_OFF_W-1:0] REG_ITER   = 'd1;
   localparam logic [REG_OFF_W-1:0] REG_PERIOD = 'd2;
   localparam logic [REG_OFF_W-1:0] REG_DUTY   = 'd3;
   localparam logic [REG_OFF_W-1:0] REG_DELAY  = 'd4;
   localparam logic [REG_OFF_W-1:0] REG_SHIFT  = 'd5;
   localparam logic [REG_OFF_W-1:0] REG_INCR   = 'd6;
   localparam logic [REG_OFF_W-1:0] REG_CTRL   = 'd7;
   localparam logic [REG_OFF_W-1:0] REG_STATUS = 'd8;

   // CTRL write bits
   localparam int CTRL_INIT_BIT  = 0;
   localparam int CTRL_RUN_BIT   = 1;
   localparam int CTRL_PAUSE_BIT = 2;

endpackage

`default_nettype wire

// ==== src/agu_data_mem.sv ====
`default_nettype none

module agu_data_mem
   import agu_pkg::*;
(
   input  logic                  clk_i,

   input  logic                  we_i,
   input  logic [MEM_ADDR_W-1:0] waddr_i,
   input  logic [MEM_DATA_W-1:0] wdata_i,

   input  logic                  re_i,
   input  logic [MEM_ADDR_W-1:0] raddr_i,
   output logic [MEM_DATA_W-1:0] rdata_o
);

   logic [MEM_DATA_W-1:0] mem [MEM_DEPTH];

   always_ff @(posedge clk_i) begin
      if (we_i)
         mem[waddr_i] <= wdata_i;
   end

   // read data holds between enables
   always_ff @(posedge clk_i) begin
      if (re_i)
         rdata_o <= mem[raddr_i];
   end

endmodule

`default_nettype wire

// ==== src/agu_addr_gen.sv ====
`default_nettype none

module agu_addr_gen
   import agu_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic                         init_i,
   input  logic                         run_i,
   input  logic                         pause_i,

   input  logic        [MEM_ADDR_W-1:0] iterations_i,
   input  logic        [  PERIOD_W-1:0] period_i,
   input  logic        [  PERIOD_W-1:0] duty_i,
   input  logic        [  PERIOD_W-1:0] delay_i,
   input  logic        [MEM_ADDR_W-1:0] start_i,
   input  logic signed [MEM_ADDR_W-1:0] shift_i,
   input  logic signed [MEM_ADDR_W-1:0] incr_i,

   output logic        [MEM_ADDR_W-1:0] addr_o,
   output logic                         mem_en_o,
   output logic                         done_o
);

   logic signed [PERIOD_W:0] per_cnt, per_cnt_nxt;  // negative while in delay
   logic [PERIOD_W:0] period_ext, duty_ext;

   logic [MEM_ADDR_W-1:0] addr_r0, addr_r1, addr_nxt;
   logic [MEM_ADDR_W-1:0] iter, iter_nxt;  // current iteration, from 1

   logic busy, busy_nxt;  // 0 idle, 1 running
   logic mem_en_nxt;
   logic done_nxt;
   logic run_pend, run_pend_nxt;  // run seen while busy

   logic full_duty;
   logic period_end;
   logic last_iter;
   logic restart;

   assign period_ext = {1'b0, period_i};
   assign duty_ext   = {1'b0, duty_i};

   assign full_duty  = (period_i == duty_i);
   assign period_end = (per_cnt == period_ext);
   assign last_iter  = (iter == iterations_i);
   assign restart    = busy & last_iter & period_end & (run_i | run_pend);

   always_comb begin
      busy_nxt     = busy;
      done_nxt     = done_o;
      mem_en_nxt   = mem_en_o;
      per_cnt_nxt  = per_cnt;
      addr_nxt     = addr_r0;
      iter_nxt     = iter;
      run_pend_nxt = run_pend;

      if (!busy) begin
         done_nxt   = 1'b1;
         mem_en_nxt = 1'b0;

         if (init_i) begin
            per_cnt_nxt = (PERIOD_W + 1)'(1) - {1'b0, delay_i};
            addr_nxt    = start_i;
            iter_nxt    = MEM_ADDR_W'(1);
         end

         if (run_i) begin
            busy_nxt     = 1'b1;
            done_nxt     = 1'b0;
            run_pend_nxt = 1'b0;
            if (delay_i == '0)
               mem_en_nxt = 1'b1;  // no delay, enable right away
         end
      end else begin
         if (run_i)
            run_pend_nxt = 1'b1;

         // duty window
         if ((per_cnt == '0 && full_duty) || period_end)
            mem_en_nxt = 1'b1;
         if (per_cnt == duty_ext && (!full_duty || last_iter))
            mem_en_nxt = 1'b0;

         per_cnt_nxt = per_cnt + 1'b1;
         if (period_end) begin
            per_cnt_nxt = (PERIOD_W + 1)'(1);
            iter_nxt    = iter + 1'b1;
         end

         if (mem_en_o)
            addr_nxt = addr_r0 + incr_i;
         if (period_end)
            addr_nxt = addr_r0 + incr_i + shift_i;  // shift at boundary
         if (mem_en_o && per_cnt == duty_ext && !full_duty)
            addr_nxt = addr_r0;

         if (last_iter && period_end) begin
            if (restart) begin
               addr_nxt     = start_i;
               iter_nxt     = MEM_ADDR_W'(1);
               mem_en_nxt   = 1'b1;
               run_pend_nxt = 1'b0;
            end else begin
               busy_nxt   = 1'b0;
               done_nxt   = 1'b1;
               mem_en_nxt = 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy     <= 1'b0;
         mem_en_o <= 1'b0;
         done_o   <= 1'b1;
         addr_r0  <= '0;
         addr_r1  <= '0;
         per_cnt  <= '0;
         iter     <= '0;
         run_pend <= 1'b0;
      end else if (pause_i) begin
         run_pend <= run_pend | (busy & run_i);  // keep runs that land in a pause
      end else begin
         busy     <= busy_nxt;
         mem_en_o <= mem_en_nxt;
         done_o   <= done_nxt;
         addr_r0  <= addr_nxt;
         addr_r1  <= addr_r0;
         per_cnt  <= per_cnt_nxt;
         iter     <= iter_nxt;
         run_pend <= run_pend_nxt;
      end
   end

   // second stage lines up with the duty window
   assign addr_o = full_duty ? addr_r0 : addr_r1;

   a_pause_holds_en: assert property (@(posedge clk_i) disable iff (rst_i)
      $past(pause_i) |-> !$rose(mem_en_o));

   a_run_clears_done: assert property (@(posedge clk_i) disable iff (rst_i)
      (!busy && run_i && !pause_i) |=> !done_o);

endmodule

`default_nettype wire

// ==== src/agu_wb_regs.sv ====
`default_nettype none

module agu_wb_regs
   import agu_pkg::*, agu_wb_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         rst_i,

   input  logic                         wb_cyc_i,
   input  logic                         wb_stb_i,
   input  logic                         wb_we_i,
   input  logic        [ WB_ADDR_W-1:0] wb_adr_i,
   input  logic        [ WB_DATA_W-1:0] wb_dat_i,
   input  logic        [  WB_SEL_W-1:0] wb_sel_i,
   output logic        [ WB_DATA_W-1:0] wb_dat_o,
   output logic                         wb_ack_o,

   input  logic                         done_i,
   output logic        [MEM_ADDR_W-1:0] iterations_o,
   output logic        [  PERIOD_W-1:0] period_o,
   output logic        [  PERIOD_W-1:0] duty_o,
   output logic        [  PERIOD_W-1:0] delay_o,
   output logic        [MEM_ADDR_W-1:0] start_o,
   output logic signed [MEM_ADDR_W-1:0] shift_o,
   output logic signed [MEM_ADDR_W-1:0] incr_o,
   output logic                         init_o,
   output logic                         run_o,
   output logic                         pause_o,

   output logic                         mem_we_o,
   output logic        [MEM_ADDR_W-1:0] mem_waddr_o,
   output logic        [MEM_DATA_W-1:0] mem_wdata_o
);

   logic                 req;
   logic                 ack_q;
   logic                 win_sel;
   logic                 full_word;
   logic                 wr_acc;
   logic                 ctrl_wr;
   logic [REG_OFF_W-1:0] reg_off;
   logic [WB_DATA_W-1:0] rd_word;
   logic [WB_DATA_W-1:0] rd_q;

   assign req       = wb_cyc_i & wb_stb_i;
   assign win_sel   = wb_adr_i[MEM_WIN_BIT];
   assign reg_off   = wb_adr_i[MEM_WIN_BIT-1:2];
   assign full_word = &wb_sel_i;  // partial writes are acked and dropped
   assign wr_acc    = ack_q & req & wb_we_i & full_word;
   assign ctrl_wr   = wr_acc & ~win_sel & (reg_off == REG_CTRL);

   assign wb_ack_o = ack_q;
   assign wb_dat_o = rd_q;

   // one-cycle command pulses in the ack cycle
   assign init_o = ctrl_wr & wb_dat_i[CTRL_INIT_BIT];
   assign run_o  = ctrl_wr & wb_dat_i[CTRL_RUN_BIT];

   assign mem_we_o    = wr_acc & win_sel;
   assign mem_waddr_o = wb_adr_i[MEM_ADDR_W+1:2];
   assign mem_wdata_o = wb_dat_i[MEM_DATA_W-1:0];

   always_ff @(posedge clk_i) begin
      if (rst_i)
         ack_q <= 1'b0;
      else
         ack_q <= req & ~ack_q;  // low again after each ack
   end

   always_comb begin
      rd_word = '0;
      if (!win_sel) begin
         case (reg_off)
            REG_START:  rd_word = WB_DATA_W'(start_o);
            REG_ITER:   rd_word = WB_DATA_W'(iterations_o);
            REG_PERIOD: rd_word = WB_DATA_W'(period_o);
            REG_DUTY:   rd_word = WB_DATA_W'(duty_o);
            REG_DELAY:  rd_word = WB_DATA_W'(delay_o);
            REG_SHIFT:  rd_word = WB_DATA_W'($unsigned(shift_o));
            REG_INCR:   rd_word = WB_DATA_W'($unsigned(incr_o));
            REG_CTRL:   rd_word[CTRL_PAUSE_BIT] = pause_o;
            REG_STATUS: rd_word[0] = done_i;
            default:    rd_word = '0;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (req && !ack_q)
         rd_q <= rd_word;
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         start_o      <= '0;
         iterations_o <= '0;
         period_o     <= '0;
         duty_o       <= '0;
         delay_o      <= '0;
         shift_o      <= '0;
         incr_o       <= '0;
         pause_o      <= 1'b0;
      end else if (wr_acc && !win_sel) begin
         case (reg_off)
            REG_START:  start_o      <= wb_dat_i[MEM_ADDR_W-1:0];
            REG_ITER:   iterations_o <= wb_dat_i[MEM_ADDR_W-1:0];
            REG_PERIOD: period_o     <= wb_dat_i[PERIOD_W-1:0];
            REG_DUTY:   duty_o       <= wb_dat_i[PERIOD_W-1:0];
            REG_DELAY:  delay_o      <= wb_dat_i[PERIOD_W-1:0];
            REG_SHIFT:  shift_o      <= wb_dat_i[MEM_ADDR_W-1:0];
            REG_INCR:   incr_o       <= wb_dat_i[MEM_ADDR_W-1:0];
            REG_CTRL:   pause_o      <= wb_dat_i[CTRL_PAUSE_BIT];  // level until next CTRL
            default:    ;
         endcase
      end
   end

   a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
      wb_ack_o |=> !wb_ack_o);

   a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
      wb_ack_o |-> wb_cyc_i);

endmodule

`default_nettype wire

// ==== src/agu_stream_top.sv ====
`default_nettype none

module agu_stream_top
   import agu_pkg::*, agu_wb_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_i,

   input  logic                  wb_cyc_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_we_i,
   input  logic [ WB_ADDR_W-1:0] wb_adr_i,
   input  logic [ WB_DATA_W-1:0] wb_dat_i,
   input  logic [  WB_SEL_W-1:0] wb_sel_i,
   output logic [ WB_DATA_W-1:0] wb_dat_o,
   output logic                  wb_ack_o,

   output logic [MEM_DATA_W-1:0] data_o,
   output logic                  valid_o
);

   logic        [MEM_ADDR_W-1:0] iterations;
   logic        [  PERIOD_W-1:0] period;
   logic        [  PERIOD_W-1:0] duty;
   logic        [  PERIOD_W-1:0] delay;
   logic        [MEM_ADDR_W-1:0] start;
   logic signed [MEM_ADDR_W-1:0] shift;
   logic signed [MEM_ADDR_W-1:0] incr;
   logic                         init;
   logic                         run;
   logic                         pause;
   logic                         done;

   logic        [MEM_ADDR_W-1:0] addr;
   logic                         mem_en;
   logic                         mem_we;
   logic        [MEM_ADDR_W-1:0] mem_waddr;
   logic        [MEM_DATA_W-1:0] mem_wdata;

   agu_wb_regs u_regs (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .wb_cyc_i     (wb_cyc_i),
      .wb_stb_i     (wb_stb_i),
      .wb_we_i      (wb_we_i),
      .wb_adr_i     (wb_adr_i),
      .wb_dat_i     (wb_dat_i),
      .wb_sel_i     (wb_sel_i),
      .wb_dat_o     (wb_dat_o),
      .wb_ack_o     (wb_ack_o),
      .done_i       (done),
      .iterations_o (iterations),
      .period_o     (period),
      .duty_o       (duty),
      .delay_o      (delay),
      .start_o      (start),
      .shift_o      (shift),
      .incr_o       (incr),
      .init_o       (init),
      .run_o        (run),
      .pause_o      (pause),
      .mem_we_o     (mem_we),
      .mem_waddr_o  (mem_waddr),
      .mem_wdata_o  (mem_wdata)
   );

   agu_addr_gen u_agen (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .init_i       (init),
      .run_i        (run),
      .pause_i      (pause),
      .iterations_i (iterations),
      .period_i     (period),
      .duty_i       (duty),
      .delay_i      (delay),
      .start_i      (start),
      .shift_i      (shift),
      .incr_i       (incr),
      .addr_o       (addr),
      .mem_en_o     (mem_en),
      .done_o       (done)
   );

   agu_data_mem u_mem (
      .clk_i   (clk_i),
      .we_i    (mem_we),
      .waddr_i (mem_waddr),
      .wdata_i (mem_wdata),
      .re_i    (mem_en),
      .raddr_i (addr),
      .rdata_o (data_o)
   );

   always_ff @(posedge clk_i) begin
      if (rst_i)
         valid_o <= 1'b0;
      else
         valid_o <= mem_en;  // matches the one-cycle read latency
   end

endmodule

`default_nettype wire

// ==== dv/agu_tb.sv ====
`default_nettype none

module agu_tb
   import agu_pkg::*, agu_wb_pkg::*;
();

   localparam logic [31:0] DATA_TAG = 32'h5A5A0000;  // preload word = address ^ tag

   logic                 clk_i = 1'b0;
   logic                 rst_i = 1'b1;
   logic                 wb_cyc_i = 1'b0;
   logic                 wb_stb_i = 1'b0;
   logic                 wb_we_i = 1'b0;
   logic [WB_ADDR_W-1:0] wb_adr_i = '0;
   logic [WB_DATA_W-1:0] wb_dat_i = '0;
   logic [ WB_SEL_W-1:0] wb_sel_i = '0;
   logic [WB_DATA_W-1:0] wb_dat_o;
   logic                 wb_ack_o;
   logic [MEM_DATA_W-1:0] data_o;
   logic                 valid_o;

   int cfg_start[$], cfg_iter[$], cfg_period[$], cfg_duty[$];
   int cfg_delay[$], cfg_shift[$], cfg_incr[$], cfg_mode[$];
   int case_base[$];
   int exp_addr[$];
   logic [31:0] got_q[$];
   logic collecting = 1'b0;
   int cycle_cnt = 0;
   int cycle_limit = 0;
   int ack_cycle = 0;    // cycle of the latest bus ack
   int first_valid = 0;
   int last_valid = 0;

   agu_stream_top uut (.*);

   always #10 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("run timed out after %0d cycles", cycle_cnt);
         $display("TESTS FAILED");
         $fatal(1, "timeout");
      end
   end

   // stream monitor on the falling edge
   always @(negedge clk_i) begin
      if (collecting && valid_o) begin
         if (got_q.size() == 0)
            first_valid = cycle_cnt;
         last_valid = cycle_cnt;
         got_q.push_back(data_o);
      end
   end

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
         $display("TESTS FAILED");
         $fatal(1, "check failed");
      end
   endtask

   task automatic idle_gap(input int max_cycles);
      int n;
      n = $urandom % (max_cycles + 1);
      repeat (n) @(posedge clk_i);
   endtask

   // classic cycle with the request held until ack
   task automatic bus_access(input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
      idle_gap(2);
      @(posedge clk_i);
      #2;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = wdat;
      wb_sel_i = '1;
      do @(negedge clk_i); while (!wb_ack_o);
      rdat = wb_dat_o;
      ack_cycle = cycle_cnt;
      @(posedge clk_i);
      #2;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic write_reg(input int off, input logic [31:0] val);
      logic [31:0] unused;
      bus_access(1'b1, WB_ADDR_W'(off * 4), val, unused);
   endtask

   task automatic read_reg(input int off, output logic [31:0] val);
      bus_access(1'b0, WB_ADDR_W'(off * 4), '0, val);
   endtask

   task automatic wait_words(input int n);
      while (got_q.size() < n)
         @(negedge clk_i);
   endtask

   task automatic load_stim();
      int fd, n, a;
      string line;
      fd = $fopen("dv/agu_stim.txt", "r");
      if (fd == 0) begin
         $display("could not open the stim file dv/agu_stim.txt");
         $display("TESTS FAILED");
         $fatal(1, "no stim");
      end
      while ($fgets(line, fd)) begin
         if (line.len() < 2 || line.getc(0) == "#")
            continue;
         cfg_start.push_back(0);
         cfg_iter.push_back(0);
         cfg_period.push_back(0);
         cfg_duty.push_back(0);
         cfg_delay.push_back(0);
         cfg_shift.push_back(0);
         cfg_incr.push_back(0);
         cfg_mode.push_back(0);
         n = cfg_start.size() - 1;
         void'($sscanf(line, "%d %d %d %d %d %d %d %d", cfg_start[n], cfg_iter[n],
                       cfg_period[n], cfg_duty[n], cfg_delay[n], cfg_shift[n],
                       cfg_incr[n], cfg_mode[n]));
         case_base.push_back(exp_addr.size());
         for (int i = 0; i < cfg_iter[n] * cfg_duty[n]; i++) begin
            void'($fscanf(fd, "%h", a));
            exp_addr.push_back(a);
         end
      end
      $fclose(fd);
   endtask

   task automatic run_case(input int c);
      int n_words;
      int runs;
      int run_ack;
      logic [31:0] rd;
      logic [31:0] seen[$];
      n_words = cfg_iter[c] * cfg_duty[c];
      runs = (cfg_mode[c] == 1) ? 2 : 1;
      got_q.delete();
      collecting = 1'b1;
      write_reg(REG_START, cfg_start[c]);
      write_reg(REG_ITER, cfg_iter[c]);
      write_reg(REG_PERIOD, cfg_period[c]);
      write_reg(REG_DUTY, cfg_duty[c]);
      write_reg(REG_DELAY, cfg_delay[c]);
      write_reg(REG_SHIFT, cfg_shift[c]);
      write_reg(REG_INCR, cfg_incr[c]);
      write_reg(REG_CTRL, 1 << CTRL_INIT_BIT);
      write_reg(REG_CTRL, 1 << CTRL_RUN_BIT);
      run_ack = ack_cycle;
      read_reg(REG_STATUS, rd);
      compare_value("status done while running", rd, 32'h0);
      if (cfg_mode[c] == 1) begin
         wait_words(n_words - cfg_duty[c] + 1);  // first word of last period
         write_reg(REG_CTRL, 1 << CTRL_RUN_BIT);
         wait_words(n_words + 1);
         read_reg(REG_STATUS, rd);
         compare_value("status done between runs", rd, 32'h0);
      end else if (cfg_mode[c] == 2) begin
         wait_words(4);
         write_reg(REG_CTRL, 1 << CTRL_PAUSE_BIT);
         repeat (3 + $urandom % 6) @(posedge clk_i);
         write_reg(REG_CTRL, 0);
      end
      do read_reg(REG_STATUS, rd); while (!rd[0]);
      repeat (4) @(negedge clk_i);
      collecting = 1'b0;

      // pause repeats words, so only the order of distinct words counts
      foreach (got_q[i])
         if (cfg_mode[c] != 2 || i == 0 || got_q[i] != got_q[i-1])
            seen.push_back(got_q[i]);
      compare_value("stream length", seen.size(), runs * n_words);
      foreach (seen[i])
         compare_value("data_o", seen[i],
                       DATA_TAG ^ exp_addr[case_base[c] + (i % n_words)]);

      // first word two cycles after the run ack, later by the delay
      compare_value("cycles from run ack to first valid", first_valid - run_ack,
                    2 + cfg_delay[c]);
      if (cfg_mode[c] == 2)
         compare_value("words held in pause", got_q.size() > seen.size(), 1);
      else
         compare_value("stream span", last_valid - first_valid + 1,
                       (runs * cfg_iter[c] - 1) * cfg_period[c] + cfg_duty[c]);
   endtask

   initial begin
      logic [31:0] rd, val;
      void'($urandom(21641));
      load_stim();
      cycle_limit = 5 * MEM_DEPTH + 500;
      foreach (cfg_iter[c])
         cycle_limit += cfg_iter[c] * cfg_period[c] * ((cfg_mode[c] == 1) ? 2 : 1)
                        + cfg_delay[c] + 300;

      repeat (5) @(posedge clk_i);
      #2;
      rst_i = 1'b0;

      read_reg(REG_STATUS, rd);
      compare_value("status done after reset", rd, 32'h1);
      for (int off = REG_START; off <= REG_INCR; off++) begin
         val = $urandom;
         write_reg(off, val);
         read_reg(off, rd);
         compare_value("register readback", rd, val & 32'h3ff);
      end

      for (int a = 0; a < MEM_DEPTH; a++)
         bus_access(1'b1, WB_ADDR_W'((1 << MEM_WIN_BIT) | (a * 4)), DATA_TAG ^ a, rd);

      foreach (cfg_iter[c])
         run_case(c);

      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/agu_stim.txt ====
# start iterations period duty delay shift incr mode (0 plain, 1 back-to-back run, 2 pause)
# each config line is followed by iterations*duty expected addresses in hex
16 3 5 3 0 8 2 0
010 010 012 014 01e 020 022 02c 02e
512 2 4 2 0 -16 -3 0
200 200 1fd 1ea
1008 3 4 4 5 -30 5 0
3f0 3f5 3fa 3ff 3e6 3eb 3f0 3f5 3dc 3e1 3e6 3eb
256 2 10 10 0 10 1 1
100 101 102 103 104 105 106 107 108 109
114 115 116 117 118 119 11a 11b 11c 11d
128 3 5 5 0 -4 2 2
080 082 084 086 088 086 088 08a 08c 08e 08c 08e 090 092 094

// ==== tb.f ====
src/agu_pkg.sv
src/agu_wb_pkg.sv
src/agu_data_mem.sv
src/agu_addr_gen.sv
src/agu_wb_regs.sv
src/agu_stream_top.sv
dv/agu_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = agu_tb
FILELIST = tb.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, pass if the log reports success"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
